//--- hdl/mmio_config.svh
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

////////////////////////////////////////
// region codes, dmem_addr[29:26]
////////////////////////////////////////

`define MMIO_REGION_VMEM   4'hc
`define MMIO_REGION_TRAP   4'hd
`define MMIO_REGION_KBD    4'he
`define MMIO_REGION_LOADER 4'hf

// sub-page of the trap region, dmem_addr[25:18]
`define MMIO_TRAP_PAGE 8'hdd

////////////////////////////////////////
// memory sizes and timing
////////////////////////////////////////

`define MMIO_LOADER_ADDR_BITS 13
`define MMIO_TEXT_ADDR_BITS   15

// character memory write window, in pipeline cycles
`define MMIO_VGA_WAIT_CYCLES 5

// scancode queue entries, power of two
`define MMIO_KB_FIFO_DEPTH 8

`endif

//--- hdl/mmio_pkg.sv
`include "mmio_config.svh"

package mmio_pkg;

    // cpu side addresses are word addresses
    typedef logic [29:0] word_addr_t;
    typedef logic [31:0] word_t;

    // one ascii character or one ps/2 scancode
    typedef logic [7:0] char_t;

    // one bit per byte lane of a word
    typedef logic [3:0] lane_mask_t;

    typedef enum logic [2:0] {
        region_main,
        region_vmem,
        region_trap,
        region_kbd,
        region_loader,
        region_unmapped
    } mmio_region_t;

    typedef logic [`MMIO_LOADER_ADDR_BITS-1:0] loader_addr_t;
    typedef logic [`MMIO_TEXT_ADDR_BITS-1:0] text_addr_t;

endpackage

//--- hdl/addr_decode.sv
`include "mmio_config.svh"

module addr_decode (
    input  mmio_pkg::word_addr_t dmem_addr,
    input  logic                 dmem_read_in,
    input  logic                 dmem_write_in,
    input  mmio_pkg::lane_mask_t dmem_byte_w_en,
    input  mmio_pkg::word_t      data_from_reg,
    input  mmio_pkg::word_addr_t instr_addr,
    input  mmio_pkg::word_t      loader_data,
    input  mmio_pkg::word_t      loader_instr,
    input  mmio_pkg::char_t      kb_keycode,
    output mmio_pkg::word_t      dmem_data_out,
    output mmio_pkg::word_t      instr_data_out,
    output mmio_pkg::lane_mask_t loader_wen,
    output logic                 vmem_request,
    output mmio_pkg::text_addr_t text_addr,
    output mmio_pkg::char_t      text_char,
    output logic                 kb_read,
    output logic                 trap_stall
);
    import mmio_pkg::*;

    mmio_region_t region;
    logic [1:0]   text_lane;

    ////////////////////////////////////////
    // region classification
    ////////////////////////////////////////

    always_comb begin
        case (dmem_addr[29:26])
            `MMIO_REGION_VMEM:   region = region_vmem;
            `MMIO_REGION_TRAP:   region = region_trap;
            `MMIO_REGION_KBD:    region = region_kbd;
            `MMIO_REGION_LOADER: region = region_loader;
            // lower half is main memory, 8..b has nothing behind it now
            default:             region = dmem_addr[29] ? region_unmapped : region_main;
        endcase
    end

    ////////////////////////////////////////
    // per-region strobes
    ////////////////////////////////////////

    always_comb begin
        vmem_request = (region == region_vmem) && dmem_write_in;
        kb_read      = (region == region_kbd) && dmem_read_in;
        trap_stall   = (region == region_trap) && (dmem_addr[25:18] == `MMIO_TRAP_PAGE)
                       && (dmem_read_in || dmem_write_in);

        // byte enable is big-endian, loader lanes are little-endian
        loader_wen = '0;
        if ((region == region_loader) && dmem_write_in) begin
            case (dmem_byte_w_en)
                4'b0001: loader_wen = 4'b1000;
                4'b0010: loader_wen = 4'b0100;
                4'b0100: loader_wen = 4'b0010;
                4'b1000: loader_wen = 4'b0001;
                default: loader_wen = 4'b1111;
            endcase
        end

        strobe_check: assert ($onehot0({vmem_request, kb_read, trap_stall, |loader_wen}));
    end

    // character write: lane picks both the byte and the low address bits
    always_comb begin
        case (dmem_byte_w_en)
            4'b1000: begin
                text_lane = 2'd0;
                text_char = data_from_reg[7:0];
            end
            4'b0100: begin
                text_lane = 2'd1;
                text_char = data_from_reg[15:8];
            end
            4'b0010: begin
                text_lane = 2'd2;
                text_char = data_from_reg[23:16];
            end
            default: begin
                text_lane = 2'd3;
                text_char = data_from_reg[31:24];
            end
        endcase
    end

    assign text_addr = {dmem_addr[`MMIO_TEXT_ADDR_BITS-3:0], text_lane};

    ////////////////////////////////////////
    // read data select
    ////////////////////////////////////////

    always_comb begin
        case (region)
            region_kbd:    dmem_data_out = {24'd0, kb_keycode};
            region_loader: dmem_data_out = loader_data;
            default:       dmem_data_out = '0;
        endcase
    end

    // only the loader can feed instructions
    assign instr_data_out = (instr_addr[29:26] == `MMIO_REGION_LOADER) ? loader_instr : '0;

endmodule

//--- hdl/block_ram.sv
module block_ram #(
    parameter type payload_t = mmio_pkg::word_t,
    parameter int  LANES     = 4,
    parameter int  ADDR_BITS = 13
) (
    input  logic                 clk_pipeline,

    // port a, read and lane write
    input  logic [ADDR_BITS-1:0] addr_a,
    input  logic [LANES-1:0]     wen_a,
    input  payload_t             din_a,
    output payload_t             dout_a,

    // port b, read only
    input  logic [ADDR_BITS-1:0] addr_b,
    output payload_t             dout_b
);

    localparam int LANE_BITS = $bits(payload_t) / LANES;

    payload_t mem [2**ADDR_BITS];

    // lane k covers bits 8k+7 down to 8k for a byte-wide lane
    always_ff @(posedge clk_pipeline) begin
        for (int k = 0; k < LANES; k++) begin
            if (wen_a[k]) begin
                mem[addr_a][k*LANE_BITS +: LANE_BITS] <= din_a[k*LANE_BITS +: LANE_BITS];
            end
        end
    end

    // registered reads on both ports, old data on a same-cycle write
    always_ff @(posedge clk_pipeline) begin
        dout_a <= mem[addr_a];
    end

    always_ff @(posedge clk_pipeline) begin
        dout_b <= mem[addr_b];
    end

endmodule

//--- hdl/vmem_write_seq.sv
`include "mmio_config.svh"

module vmem_write_seq (
    input  logic clk_pipeline,
    input  logic rst,
    input  logic vmem_request,
    output logic text_wen,
    output logic vmem_stall
);

    localparam int WAIT    = `MMIO_VGA_WAIT_CYCLES;
    localparam int CNT_MAX = WAIT + 3;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    logic [CNT_W-1:0] wait_cnt;

    ////////////////////////////////////////
    // write window counter
    ////////////////////////////////////////

    // restarts whenever the pipeline moves off the vmem write
    always_ff @(posedge clk_pipeline) begin
        if (!rst || !vmem_request) begin
            wait_cnt <= '0;
        end else if (wait_cnt != CNT_W'(CNT_MAX)) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // same char rewritten every cycle of the window
    assign text_wen = vmem_request && (wait_cnt <= CNT_W'(WAIT));

    // two extra cycles so the last write has landed before release
    assign vmem_stall = vmem_request && (wait_cnt <= CNT_W'(WAIT + 2));

    // a new request always opens the write window
    wen_at_request: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        !vmem_request ##1 vmem_request |-> text_wen
    );

    // a held request releases the pipeline exactly once, then stays free
    stall_released: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        vmem_request && !vmem_stall |=> !vmem_request || !vmem_stall
    );

endmodule

//--- hdl/ps2_keyboard.sv
`include "mmio_config.svh"

module ps2_keyboard (
    input  logic            clk_pipeline,
    input  logic            rst,
    input  logic            ps2_clk,
    input  logic            ps2_data,
    input  logic            kb_read,
    output mmio_pkg::char_t kb_keycode,
    output logic            kb_ready,
    output logic            kb_overflow
);
    import mmio_pkg::*;

    localparam int DEPTH    = `MMIO_KB_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    logic [2:0]          ps2_clk_sync;
    logic [1:0]          ps2_data_sync;
    logic                ps2_fall;
    logic [3:0]          bit_cnt;
    logic [9:0]          shift_reg;
    logic                frame_done;
    logic                frame_ok;
    char_t               fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;
    logic                fifo_full;
    logic                do_push;
    logic                do_pop;

    ////////////////////////////////////////
    // ps/2 frame receiver
    ////////////////////////////////////////

    // two sync stages, third bit is the edge history
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            ps2_clk_sync  <= 3'b111;
            ps2_data_sync <= 2'b11;
        end else begin
            ps2_clk_sync  <= {ps2_clk_sync[1:0], ps2_clk};
            ps2_data_sync <= {ps2_data_sync[0], ps2_data};
        end
    end

    assign ps2_fall = ps2_clk_sync[2] && !ps2_clk_sync[1];

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            bit_cnt <= '0;
        end else if (ps2_fall) begin
            bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    // lsb first, so after ten bits: start in [0], data in [8:1], parity in [9]
    always_ff @(posedge clk_pipeline) begin
        if (ps2_fall) begin
            shift_reg <= {ps2_data_sync[1], shift_reg[9:1]};
        end
    end

    // stop bit is the one arriving now
    assign frame_done = ps2_fall && (bit_cnt == 4'd10);
    assign frame_ok   = !shift_reg[0] && ps2_data_sync[1] && (^shift_reg[9:1]);

    ////////////////////////////////////////
    // scancode fifo
    ////////////////////////////////////////

    assign fifo_full = (count == (PTR_BITS + 1)'(DEPTH));
    assign kb_ready  = (count != '0);
    assign do_push   = frame_done && frame_ok && !fifo_full;
    assign do_pop    = kb_read && kb_ready;

    always_ff @(posedge clk_pipeline) begin
        if (do_push) begin
            fifo_mem[tail] <= shift_reg[8:1];
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            kb_overflow <= 1'b0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            count <= count + (PTR_BITS + 1)'(do_push) - (PTR_BITS + 1)'(do_pop);
            // sticky, a lost scancode is never recovered
            if (frame_done && frame_ok && fifo_full) begin
                kb_overflow <= 1'b1;
            end
        end
    end

    assign kb_keycode = fifo_mem[head];

    // pointers show a non-empty queue at every pop
    pop_not_empty: assert property (
        @(posedge clk_pipeline) disable iff (!rst)
        do_pop |-> (count == DEPTH || head != tail)
    );

endmodule

//--- hdl/cpu_interface.sv
`include "mmio_config.svh"

module cpu_interface (
    input  logic                 clk_pipeline,
    input  logic                 rst,

    // pipeline ports
    input  mmio_pkg::word_addr_t instr_addr,
    input  logic                 dmem_read_in,
    input  logic                 dmem_write_in,
    input  mmio_pkg::word_addr_t dmem_addr,
    input  mmio_pkg::word_t      data_from_reg,
    input  mmio_pkg::lane_mask_t dmem_byte_w_en,
    output mmio_pkg::word_t      instr_data_out,
    output mmio_pkg::word_t      dmem_data_out,
    output logic                 mem_stall,
    output logic                 trap_stall,

    // keyboard
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    output logic                 kb_ready,
    output logic                 kb_overflow,

    // display side of the character memory
    input  mmio_pkg::text_addr_t text_rd_addr,
    output mmio_pkg::char_t      text_rd_char
);
    import mmio_pkg::*;

    word_t      loader_data;
    word_t      loader_instr;
    lane_mask_t loader_wen;
    logic       vmem_request;
    text_addr_t text_addr;
    char_t      text_char;
    logic       text_wen;
    logic       vmem_stall;
    logic       kb_read;
    char_t      kb_keycode;

    addr_decode u_decode (
        .dmem_addr      (dmem_addr),
        .dmem_read_in   (dmem_read_in),
        .dmem_write_in  (dmem_write_in),
        .dmem_byte_w_en (dmem_byte_w_en),
        .data_from_reg  (data_from_reg),
        .instr_addr     (instr_addr),
        .loader_data    (loader_data),
        .loader_instr   (loader_instr),
        .kb_keycode     (kb_keycode),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out),
        .loader_wen     (loader_wen),
        .vmem_request   (vmem_request),
        .text_addr      (text_addr),
        .text_char      (text_char),
        .kb_read        (kb_read),
        .trap_stall     (trap_stall)
    );

    ////////////////////////////////////////
    // memories
    ////////////////////////////////////////

    // data port on a, instruction fetch on b
    block_ram #(
        .payload_t (word_t),
        .LANES     (4),
        .ADDR_BITS (`MMIO_LOADER_ADDR_BITS)
    ) u_loader (
        .clk_pipeline (clk_pipeline),
        .addr_a       (dmem_addr[`MMIO_LOADER_ADDR_BITS-1:0]),
        .wen_a        (loader_wen),
        .din_a        (data_from_reg),
        .dout_a       (loader_data),
        .addr_b       (instr_addr[`MMIO_LOADER_ADDR_BITS-1:0]),
        .dout_b       (loader_instr)
    );

    // cpu writes on a, display reads on b
    block_ram #(
        .payload_t (char_t),
        .LANES     (1),
        .ADDR_BITS (`MMIO_TEXT_ADDR_BITS)
    ) u_text_mem (
        .clk_pipeline (clk_pipeline),
        .addr_a       (text_addr),
        .wen_a        (text_wen),
        .din_a        (text_char),
        .dout_a       (),
        .addr_b       (text_rd_addr),
        .dout_b       (text_rd_char)
    );

    vmem_write_seq u_vmem_seq (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .vmem_request (vmem_request),
        .text_wen     (text_wen),
        .vmem_stall   (vmem_stall)
    );

    ps2_keyboard u_keyboard (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .kb_read      (kb_read),
        .kb_keycode   (kb_keycode),
        .kb_ready     (kb_ready),
        .kb_overflow  (kb_overflow)
    );

    // reading an empty keyboard queue waits for the next scancode
    assign mem_stall = vmem_stall || (kb_read && !kb_ready) || trap_stall;

endmodule

//--- bench/mmio_checker.sv
`include "mmio_config.svh"

module mmio_checker (
    input  logic                 sample,
    input  logic                 push_strobe,
    input  logic [7:0]           push_code,
    input  int                   test_id,
    input  logic [3:0]           kind,
    input  logic [31:0]          exp_val,
    input  int                   stall_cycles,
    input  mmio_pkg::word_addr_t dmem_addr,
    input  mmio_pkg::lane_mask_t dmem_byte_w_en,
    input  mmio_pkg::word_t      data_from_reg,
    input  mmio_pkg::word_addr_t instr_addr,
    input  mmio_pkg::text_addr_t text_rd_addr,
    input  mmio_pkg::word_t      dmem_data_out,
    input  mmio_pkg::word_t      instr_data_out,
    input  logic                 mem_stall,
    input  logic                 trap_stall,
    input  logic                 kb_ready,
    input  logic                 kb_overflow,
    input  mmio_pkg::char_t      text_rd_char,
    output int                   pass_count,
    output int                   fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] K_WR      = 4'd0;
    localparam logic [3:0] K_RD      = 4'd1;
    localparam logic [3:0] K_IF      = 4'd2;
    localparam logic [3:0] K_VW      = 4'd3;
    localparam logic [3:0] K_TXT     = 4'd4;
    localparam logic [3:0] K_TRAP_RD = 4'd5;
    localparam logic [3:0] K_TRAP_WR = 4'd6;
    localparam logic [3:0] K_KRD     = 4'd8;
    localparam logic [3:0] K_KWAIT   = 4'd9;
    localparam logic [3:0] K_OVF     = 4'd10;
    localparam logic [3:0] K_EMPTY   = 4'd11;

    logic [31:0] loader_model [int];
    logic [7:0]  text_model [int];
    logic [7:0]  fifo_model [$];
    logic        ovf_model = 1'b0;
    int          test_errors;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // keyboard queue of depth 8, extra bytes are lost
    always @(posedge push_strobe) begin
        if (fifo_model.size() < `MMIO_KB_FIFO_DEPTH) begin
            fifo_model.push_back(push_code);
        end else begin
            ovf_model = 1'b1;
        end
    end

    task automatic compare(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, want);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic report(string what);
        $display("test %0d: %s", test_id, what);
        test_errors = test_errors + 1;
    endtask

    function automatic logic [1:0] lane_of(logic [3:0] be);
        case (be)
            4'b1000: return 2'd0;
            4'b0100: return 2'd1;
            4'b0010: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    ////////////////////////////////////////
    // per-test comparison
    ////////////////////////////////////////

    always @(posedge sample) begin : compare_block
        logic [31:0] word;
        logic [1:0]  lane;
        int          key;
        test_errors = 0;
        case (kind)
            K_WR: begin
                compare("mem_stall cycles", stall_cycles, 0);
                key  = int'(dmem_addr[12:0]);
                word = loader_model.exists(key) ? loader_model[key] : 32'h0;
                // single-hot enable hits one reversed lane, others write all
                for (int k = 0; k < 4; k++) begin
                    if (!$onehot(dmem_byte_w_en) || dmem_byte_w_en[3 - k]) begin
                        word[8*k +: 8] = data_from_reg[8*k +: 8];
                    end
                end
                loader_model[key] = word;
            end
            K_RD: begin
                compare("mem_stall cycles", stall_cycles, 0);
                key  = int'(dmem_addr[12:0]);
                word = exp_val;
                if (dmem_addr[29:26] == `MMIO_REGION_LOADER) begin
                    word = loader_model.exists(key) ? loader_model[key] : 32'h0;
                end
                compare("dmem_data_out", dmem_data_out, word);
            end
            K_IF: begin
                key  = int'(instr_addr[12:0]);
                word = 32'h0;
                if (instr_addr[29:26] == `MMIO_REGION_LOADER && loader_model.exists(key)) begin
                    word = loader_model[key];
                end
                compare("instr_data_out", instr_data_out, word);
            end
            K_VW: begin
                compare("mem_stall cycles", stall_cycles, 8);
                lane = lane_of(dmem_byte_w_en);
                key  = int'({dmem_addr[12:0], lane});
                text_model[key] = data_from_reg[8*lane +: 8];
            end
            K_TXT: begin
                key = int'(text_rd_addr);
                if (text_model.exists(key)) begin
                    compare("text_rd_char", 32'(text_rd_char), 32'(text_model[key]));
                end else begin
                    report("no character was written at this text address");
                end
            end
            K_TRAP_RD, K_TRAP_WR: begin
                compare("trap_stall", 32'(trap_stall), 32'h1);
                compare("mem_stall", 32'(mem_stall), 32'h1);
                compare("mem_stall cycles", stall_cycles, 4);
            end
            K_KRD, K_KWAIT: begin
                if (fifo_model.size() == 0) begin
                    report("keyboard read with no scancode sent");
                end else begin
                    word = {24'd0, fifo_model.pop_front()};
                    compare("dmem_data_out", dmem_data_out, word);
                end
                if (kind == K_KRD) begin
                    compare("mem_stall cycles", stall_cycles, 0);
                end else if (stall_cycles == 0) begin
                    report("read of an empty keyboard queue did not stall");
                end
            end
            K_OVF: begin
                compare("kb_overflow", 32'(kb_overflow), 32'(ovf_model));
                compare("kb_overflow", 32'(kb_overflow), exp_val);
                compare("kb_ready", 32'(kb_ready), 32'(fifo_model.size() != 0));
            end
            K_EMPTY: begin
                compare("kb_ready", 32'(kb_ready), 32'(fifo_model.size() != 0));
                compare("kb_ready", 32'(kb_ready), exp_val);
            end
            default: report("unknown test kind");
        endcase
        if (test_errors == 0) begin
            pass_count = pass_count + 1;
            $display("test %0d kind %0d ok", test_id, kind);
        end else begin
            fail_count = fail_count + 1;
            $display("test %0d kind %0d failed", test_id, kind);
        end
    end

endmodule

//--- bench/tb_cpu_interface.sv
module tb_cpu_interface;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] K_WR      = 4'd0;
    localparam logic [3:0] K_RD      = 4'd1;
    localparam logic [3:0] K_IF      = 4'd2;
    localparam logic [3:0] K_VW      = 4'd3;
    localparam logic [3:0] K_TXT     = 4'd4;
    localparam logic [3:0] K_TRAP_RD = 4'd5;
    localparam logic [3:0] K_TRAP_WR = 4'd6;
    localparam logic [3:0] K_FRAME   = 4'd7;
    localparam logic [3:0] K_KRD     = 4'd8;
    localparam logic [3:0] K_KWAIT   = 4'd9;
    localparam logic [3:0] K_OVF     = 4'd10;
    localparam logic [3:0] K_EMPTY   = 4'd11;

    // 11 bits of 8 cycles each, then an idle high phase
    localparam int PS2_HALF     = 4;
    localparam int FRAME_CYCLES = 11 * 2 * PS2_HALF + PS2_HALF;
    localparam int TRAP_HOLD    = 4;
    localparam logic [29:0] KBD_ADDR = 30'h3800_0000;

    typedef struct packed {
        logic [3:0]  kind;
        logic [29:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        logic [31:0] exp_val;
    } entry_t;

    logic                 clk_pipeline;
    logic                 rst;
    mmio_pkg::word_addr_t instr_addr;
    logic                 dmem_read_in;
    logic                 dmem_write_in;
    mmio_pkg::word_addr_t dmem_addr;
    mmio_pkg::word_t      data_from_reg;
    mmio_pkg::lane_mask_t dmem_byte_w_en;
    logic                 ps2_clk;
    logic                 ps2_data;
    mmio_pkg::text_addr_t text_rd_addr;
    mmio_pkg::word_t      instr_data_out;
    mmio_pkg::word_t      dmem_data_out;
    logic                 mem_stall;
    logic                 trap_stall;
    logic                 kb_ready;
    logic                 kb_overflow;
    mmio_pkg::char_t      text_rd_char;

    entry_t      stim[$];
    logic        sample;
    logic        push_strobe;
    logic [7:0]  push_code;
    int          cur_id;
    logic [3:0]  cur_kind;
    logic [31:0] cur_exp;
    int          stall_cycles;
    int          pass_count;
    int          fail_count;
    int          cycles;
    int          limit;
    integer      seed;

    cpu_interface dut (
        .clk_pipeline   (clk_pipeline),
        .rst            (rst),
        .instr_addr     (instr_addr),
        .dmem_read_in   (dmem_read_in),
        .dmem_write_in  (dmem_write_in),
        .dmem_addr      (dmem_addr),
        .data_from_reg  (data_from_reg),
        .dmem_byte_w_en (dmem_byte_w_en),
        .instr_data_out (instr_data_out),
        .dmem_data_out  (dmem_data_out),
        .mem_stall      (mem_stall),
        .trap_stall     (trap_stall),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .kb_ready       (kb_ready),
        .kb_overflow    (kb_overflow),
        .text_rd_addr   (text_rd_addr),
        .text_rd_char   (text_rd_char)
    );

    mmio_checker u_checker (
        .sample         (sample),
        .push_strobe    (push_strobe),
        .push_code      (push_code),
        .test_id        (cur_id),
        .kind           (cur_kind),
        .exp_val        (cur_exp),
        .stall_cycles   (stall_cycles),
        .dmem_addr      (dut.dmem_addr),
        .dmem_byte_w_en (dut.dmem_byte_w_en),
        .data_from_reg  (dut.data_from_reg),
        .instr_addr     (dut.instr_addr),
        .text_rd_addr   (dut.text_rd_addr),
        .dmem_data_out  (dut.dmem_data_out),
        .instr_data_out (dut.instr_data_out),
        .mem_stall      (dut.mem_stall),
        .trap_stall     (dut.trap_stall),
        .kb_ready       (dut.kb_ready),
        .kb_overflow    (dut.kb_overflow),
        .text_rd_char   (dut.text_rd_char),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    initial clk_pipeline = 1'b0;
    always #50 clk_pipeline = ~clk_pipeline;

    // run limit
    always @(posedge clk_pipeline) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic void add_entry(logic [3:0] kind, logic [29:0] addr, logic [3:0] be,
                                      logic [31:0] data, logic [31:0] exp_val);
        entry_t e;
        e.kind    = kind;
        e.addr    = addr;
        e.be      = be;
        e.data    = data;
        e.exp_val = exp_val;
        stim.push_back(e);
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk_pipeline);
        #1;
    endtask

    task automatic take_sample();
        #1 sample = 1'b1;
        #1 sample = 1'b0;
    endtask

    // start 0, data lsb first, odd parity, stop 1
    task automatic send_frame(logic [7:0] code);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            ps2_clk  = 1'b1;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            if (i == 10) begin
                push_code   = code;
                push_strobe = 1'b1;
                #1 push_strobe = 1'b0;
            end
            wait_cycles(PS2_HALF);
        end
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        wait_cycles(PS2_HALF);
    endtask

    task automatic wait_release();
        @(negedge clk_pipeline);
        while (mem_stall) begin
            stall_cycles = stall_cycles + 1;
            @(negedge clk_pipeline);
        end
    endtask

    task automatic go_idle();
        @(posedge clk_pipeline);
        #1;
        dmem_read_in  = 1'b0;
        dmem_write_in = 1'b0;
    endtask

    ////////////////////////////////////////
    // one table entry
    ////////////////////////////////////////

    task automatic apply_entry(entry_t e);
        logic [7:0] code;
        cur_kind     = e.kind;
        cur_exp      = e.exp_val;
        stall_cycles = 0;
        case (e.kind)
            K_WR, K_VW, K_TRAP_WR: begin
                dmem_addr      = e.addr;
                dmem_byte_w_en = e.be;
                data_from_reg  = e.data;
                dmem_write_in  = 1'b1;
            end
            K_RD, K_TRAP_RD: begin
                dmem_addr    = e.addr;
                dmem_read_in = 1'b1;
            end
            K_KRD, K_KWAIT: begin
                dmem_addr    = KBD_ADDR;
                dmem_read_in = 1'b1;
            end
            K_IF:    instr_addr = e.addr;
            K_TXT:   text_rd_addr = e.data[14:0];
            default: ;
        endcase

        case (e.kind)
            K_FRAME: begin
                code = 8'($random(seed));
                send_frame(code);
            end
            K_TRAP_RD, K_TRAP_WR: begin
                repeat (TRAP_HOLD) begin
                    @(negedge clk_pipeline);
                    if (mem_stall) stall_cycles = stall_cycles + 1;
                end
                take_sample();
                go_idle();
            end
            K_KWAIT: begin
                code = 8'($random(seed));
                fork
                    send_frame(code);
                    begin
                        wait_release();
                        take_sample();
                    end
                join
                go_idle();
            end
            K_OVF, K_EMPTY: begin
                @(negedge clk_pipeline);
                take_sample();
                wait_cycles(1);
            end
            default: begin
                wait_release();
                // registered ram outputs need the second cycle
                if (e.kind == K_RD || e.kind == K_IF || e.kind == K_TXT) begin
                    @(negedge clk_pipeline);
                end
                take_sample();
                go_idle();
            end
        endcase
    endtask

    initial begin
        seed           = 6;
        cycles         = 0;
        limit          = 0;
        sample         = 1'b0;
        push_strobe    = 1'b0;
        push_code      = 8'h00;
        cur_id         = 0;
        cur_kind       = K_WR;
        cur_exp        = 32'h0;
        stall_cycles   = 0;
        rst            = 1'b0;
        instr_addr     = 30'h0;
        dmem_read_in   = 1'b0;
        dmem_write_in  = 1'b0;
        dmem_addr      = 30'h0;
        data_from_reg  = 32'h0;
        dmem_byte_w_en = 4'b0000;
        ps2_clk        = 1'b1;
        ps2_data       = 1'b1;
        text_rd_addr   = '0;

        // loader lanes, then fetches
        add_entry(K_WR, 30'h3c00_0010, 4'b1111, 32'h1122_3344, 32'h0);
        add_entry(K_RD, 30'h3c00_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_WR, 30'h3c00_0010, 4'b1000, 32'h0000_00aa, 32'h0);
        add_entry(K_RD, 30'h3c00_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_WR, 30'h3c00_0010, 4'b0100, 32'h0000_bb00, 32'h0);
        add_entry(K_WR, 30'h3c00_0010, 4'b0010, 32'h00cc_0000, 32'h0);
        add_entry(K_WR, 30'h3c00_0010, 4'b0001, 32'hdd00_0000, 32'h0);
        add_entry(K_RD, 30'h3c00_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_WR, 30'h3c00_0011, 4'b0110, 32'hcafe_f00d, 32'h0);
        add_entry(K_RD, 30'h3c00_0011, 4'b0000, 32'h0, 32'h0);
        add_entry(K_IF, 30'h3c00_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_IF, 30'h3c00_0011, 4'b0000, 32'h0, 32'h0);
        add_entry(K_IF, 30'h0000_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_IF, 30'h3000_0010, 4'b0000, 32'h0, 32'h0);

        // character writes, data column of K_TXT is the text address
        add_entry(K_VW,  30'h3000_0012, 4'b1000, 32'h4142_4344, 32'h0);
        add_entry(K_TXT, 30'h0,         4'b0000, 32'h0000_0048, 32'h0);
        add_entry(K_VW,  30'h3000_0013, 4'b0100, 32'h4142_4344, 32'h0);
        add_entry(K_TXT, 30'h0,         4'b0000, 32'h0000_004d, 32'h0);
        add_entry(K_VW,  30'h3000_0014, 4'b0010, 32'h4142_4344, 32'h0);
        add_entry(K_TXT, 30'h0,         4'b0000, 32'h0000_0052, 32'h0);
        add_entry(K_VW,  30'h3000_0015, 4'b0001, 32'h4142_4344, 32'h0);
        add_entry(K_TXT, 30'h0,         4'b0000, 32'h0000_0057, 32'h0);

        // trap page and the zero regions, low bits alias written loader words
        add_entry(K_TRAP_RD, 30'h3774_0000, 4'b0000, 32'h0, 32'h0);
        add_entry(K_TRAP_WR, 30'h3774_0005, 4'b1111, 32'h1234_5678, 32'h0);
        add_entry(K_RD, 30'h3448_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_RD, 30'h2000_0011, 4'b0000, 32'h0, 32'h0);
        add_entry(K_RD, 30'h2c00_0010, 4'b0000, 32'h0, 32'h0);
        add_entry(K_RD, 30'h0000_0011, 4'b0000, 32'h0, 32'h0);
        add_entry(K_RD, 30'h1000_0010, 4'b0000, 32'h0, 32'h0);

        // keyboard order, then the stalled read
        repeat (3) add_entry(K_FRAME, 30'h0, 4'b0000, 32'h0, 32'h0);
        repeat (3) add_entry(K_KRD, 30'h0, 4'b0000, 32'h0, 32'h0);
        add_entry(K_KWAIT, 30'h0, 4'b0000, 32'h0, 32'h0);

        // overflow
        repeat (9) add_entry(K_FRAME, 30'h0, 4'b0000, 32'h0, 32'h0);
        add_entry(K_OVF, 30'h0, 4'b0000, 32'h0, 32'h1);
        repeat (8) add_entry(K_KRD, 30'h0, 4'b0000, 32'h0, 32'h0);
        add_entry(K_EMPTY, 30'h0, 4'b0000, 32'h0, 32'h0);

        limit = stim.size() * 20 + FRAME_CYCLES * 12;

        wait_cycles(3);
        rst = 1'b1;

        foreach (stim[i]) begin
            cur_id = i;
            apply_entry(stim[i]);
        end
        wait_cycles(2);

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/mmio_pkg.sv
hdl/addr_decode.sv
hdl/block_ram.sv
hdl/vmem_write_seq.sv
hdl/ps2_keyboard.sv
hdl/cpu_interface.sv
bench/mmio_checker.sv
bench/tb_cpu_interface.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu_interface
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_bin
	out="$$(./obj_dir/sim_bin)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
